//--- design/rv_decode.sv
`include "rv_mini_defines.svh"

module rv_decode (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     decode_en,
  input  rv_mini_pkg::instr_t      instr,
  input  rv_mini_pkg::word_t       pc_in,
  input  logic                     wb_en,
  input  rv_mini_pkg::reg_addr_t   wb_rd,
  input  rv_mini_pkg::word_t       wb_data,
  input  rv_mini_pkg::reg_addr_t   dbg_addr,
  output rv_mini_pkg::word_t       pc,
  output rv_mini_pkg::word_t       rs1_data,
  output rv_mini_pkg::word_t       rs2_data,
  output rv_mini_pkg::reg_addr_t   rd,
  output rv_mini_pkg::word_t       immediate,
  output rv_mini_pkg::alu_op_e     alu_op,
  output rv_mini_pkg::branch_e     branch,
  output logic                     mem_read,
  output logic                     mem_write,
  output logic                     reg_write,
  output logic                     use_imm,
  output logic                     use_pc,
  output logic                     illegal,
  output logic                     is_ecall,
  output rv_mini_pkg::word_t       dbg_data
);

  import rv_mini_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  word_t       rs1_val;
  word_t       rs2_val;
  word_t       imm_sext;
  instr_type_e instr_type;
  alu_op_e     nxt_alu_op;
  branch_e     nxt_branch;
  logic        nxt_mem_read;
  logic        nxt_mem_write;
  logic        nxt_reg_write;
  logic        nxt_use_imm;
  logic        nxt_use_pc;
  logic        nxt_ecall;
  logic        legal;

  assign opcode    = instr[6:0];
  assign funct3    = instr[14:12];
  assign funct7    = instr[31:25];
  assign rs1       = instr[19:15];
  assign rs2       = instr[24:20];
  assign nxt_ecall = (instr == `RV_ECALL_WORD);

  rv_reg_file u_reg_file (
    .clk     (clk),
    .a1      (rs1),
    .a2      (rs2),
    .a3      (wb_rd),
    .wd      (wb_data),
    .we      (wb_en),
    .dbg_addr(dbg_addr),
    .d1      (rs1_val),
    .d2      (rs2_val),
    .dbg_d   (dbg_data)
  );

  always_comb begin
    instr_type    = INVALID_TYPE;
    nxt_alu_op    = ALU_INVALID;
    nxt_branch    = BR_NONE;
    nxt_mem_read  = 1'b0;
    nxt_mem_write = 1'b0;
    nxt_reg_write = 1'b0;
    nxt_use_imm   = 1'b0;
    nxt_use_pc    = 1'b0;
    legal         = 1'b0;
    case (opcode)
      7'b0110011: begin  // ADD, SUB
        instr_type    = R_TYPE;
        nxt_reg_write = 1'b1;
        legal         = (funct3 == 3'b000) && (funct7 == 7'b0000000 || funct7 == 7'b0100000);
        nxt_alu_op    = funct7[5] ? ALU_SUB : ALU_ADD;
      end
      7'b0010011, 7'b0000011: begin  // ADDI, LW
        instr_type    = I_TYPE;
        nxt_alu_op    = ALU_ADD;
        nxt_reg_write = 1'b1;
        nxt_use_imm   = 1'b1;
        nxt_mem_read  = opcode[4] == 1'b0;
        legal         = funct3 == (opcode[4] ? 3'b000 : 3'b010);
      end
      7'b0100011: begin  // SW
        instr_type    = S_TYPE;
        nxt_alu_op    = ALU_ADD;
        nxt_mem_write = 1'b1;
        nxt_use_imm   = 1'b1;
        legal         = (funct3 == 3'b010);
      end
      7'b1100011: begin  // BEQ, BNE
        instr_type  = B_TYPE;
        nxt_alu_op  = ALU_ADD;  // Target is pc + imm
        nxt_use_imm = 1'b1;
        nxt_use_pc  = 1'b1;
        nxt_branch  = funct3[0] ? BR_NE : BR_EQ;
        legal       = (funct3[2:1] == 2'b00);
      end
      7'b0110111: begin  // LUI
        instr_type    = U_TYPE;
        nxt_alu_op    = ALU_PASS_B;
        nxt_reg_write = 1'b1;
        nxt_use_imm   = 1'b1;
        legal         = 1'b1;
      end
      7'b1101111: begin  // JAL
        instr_type    = J_TYPE;
        nxt_alu_op    = ALU_ADD;
        nxt_branch    = BR_JAL;
        nxt_reg_write = 1'b1;
        nxt_use_imm   = 1'b1;
        nxt_use_pc    = 1'b1;
        legal         = 1'b1;
      end
      7'b1110011: begin  // Only ECALL of the system group
        instr_type = I_TYPE;
        nxt_alu_op = ALU_ADD;
        legal      = nxt_ecall;
      end
      default: ;
    endcase
  end

  // Needed in the decode cycle itself, so not registered
  assign illegal = (instr_type == INVALID_TYPE) || !legal;

  always_comb begin
    case (instr_type)
      I_TYPE:  imm_sext = {{20{instr[31]}}, instr[31:20]};
      S_TYPE:  imm_sext = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      B_TYPE:  imm_sext = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      U_TYPE:  imm_sext = {instr[31:12], 12'b0};
      J_TYPE:  imm_sext = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm_sext = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      alu_op    <= ALU_INVALID;
      branch    <= BR_NONE;
      mem_read  <= 1'b0;
      mem_write <= 1'b0;
      reg_write <= 1'b0;
      is_ecall  <= 1'b0;
    end else if (decode_en) begin
      alu_op    <= nxt_alu_op;
      branch    <= nxt_branch;
      mem_read  <= nxt_mem_read;
      mem_write <= nxt_mem_write;
      reg_write <= nxt_reg_write;
      is_ecall  <= nxt_ecall;
    end
  end

  always_ff @(posedge clk) begin
    if (decode_en) begin
      pc        <= pc_in;
      rs1_data  <= rs1_val;
      rs2_data  <= rs2_val;
      rd        <= instr[11:7];
      immediate <= imm_sext;
      use_imm   <= nxt_use_imm;
      use_pc    <= nxt_use_pc;
    end
  end

  a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n) !(mem_read && mem_write));

endmodule

//--- design/rv_execute.sv
`include "rv_mini_defines.svh"

module rv_execute (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   execute_en,
  input  rv_mini_pkg::word_t     pc,
  input  rv_mini_pkg::word_t     rs1_data,
  input  rv_mini_pkg::word_t     rs2_data,
  input  rv_mini_pkg::reg_addr_t rd,
  input  rv_mini_pkg::word_t     immediate,
  input  rv_mini_pkg::alu_op_e   alu_op,
  input  rv_mini_pkg::branch_e   branch,
  input  logic                   mem_read,
  input  logic                   mem_write,
  input  logic                   reg_write,
  input  logic                   use_imm,
  input  logic                   use_pc,
  output logic                   wb_en,
  output rv_mini_pkg::reg_addr_t wb_rd,
  output rv_mini_pkg::word_t     wb_data,
  output rv_mini_pkg::word_t     next_pc
);

  import rv_mini_pkg::*;

  word_t                  op_a;
  word_t                  op_b;
  word_t                  alu_result;
  word_t                  pc_plus4;
  logic                   taken;
  logic [`RV_DMEM_AW-1:0] dmem_addr;
  word_t                  dmem [2**`RV_DMEM_AW];

  assign op_a      = use_pc ? pc : rs1_data;
  assign op_b      = use_imm ? immediate : rs2_data;
  assign pc_plus4  = pc + 32'd4;
  assign dmem_addr = alu_result[`RV_DMEM_AW+1:2];  // Word index of the sum

  always_comb begin
    case (alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_PASS_B: alu_result = op_b;  // LUI
      default:    alu_result = '0;
    endcase
  end

  always_comb begin
    case (branch)
      BR_EQ:   taken = (rs1_data == rs2_data);
      BR_NE:   taken = (rs1_data != rs2_data);
      BR_JAL:  taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (execute_en) begin
      if (mem_write) dmem[dmem_addr] <= rs2_data;
      wb_rd   <= rd;
      next_pc <= taken ? alu_result : pc_plus4;
      if (mem_read) wb_data <= dmem[dmem_addr];
      else if (branch == BR_JAL) wb_data <= pc_plus4;  // Link address
      else wb_data <= alu_result;
    end
  end

  // One-cycle pulse, lands in the writeback step
  always_ff @(posedge clk) begin
    if (!rst_n) wb_en <= 1'b0;
    else wb_en <= execute_en && reg_write;
  end

endmodule

//--- design/rv_fetch.sv
`include "rv_mini_defines.svh"

module rv_fetch (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    prog_we,
  input  rv_mini_pkg::imem_addr_t prog_addr,
  input  rv_mini_pkg::instr_t     prog_data,
  input  logic                    pc_reset,
  input  logic                    fetch_en,
  input  logic                    writeback_en,
  input  rv_mini_pkg::word_t      next_pc,
  output rv_mini_pkg::word_t      pc,
  output rv_mini_pkg::instr_t     instr
);

  import rv_mini_pkg::*;

  instr_t     imem [2**`RV_IMEM_AW];
  imem_addr_t fetch_addr;

  assign fetch_addr = pc[`RV_IMEM_AW+1:2];  // Drop byte offset

  always_ff @(posedge clk) begin
    if (prog_we) imem[prog_addr] <= prog_data;  // Load port
    if (fetch_en) instr <= imem[fetch_addr];
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else if (pc_reset) begin
      pc <= `RV_RESET_PC;
    end else if (writeback_en) begin
      pc <= next_pc;  // Resolved in execute
    end
  end

  // Branch and JAL targets come from execute, alignment must survive every update
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    writeback_en |=> pc[1:0] == 2'b00);

endmodule

//--- design/rv_mini_defines.svh
`ifndef RV_MINI_DEFINES_SVH
`define RV_MINI_DEFINES_SVH

// Instruction memory depth as a word address width
`define RV_IMEM_AW 8

// Data memory depth as a word address width
`define RV_DMEM_AW 8

`define RV_RESET_PC 32'h0000_0000

// ECALL is fully fixed, all fields other than opcode are zero
`define RV_ECALL_WORD 32'h0000_0073

`endif

//--- design/rv_mini_pkg.sv
`include "rv_mini_defines.svh"

package rv_mini_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [`RV_IMEM_AW-1:0] imem_addr_t;  // Word index, not byte address

  typedef enum logic [2:0] {
    R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE, INVALID_TYPE
  } instr_type_e;

  typedef enum logic [1:0] {
    ALU_ADD, ALU_SUB, ALU_PASS_B, ALU_INVALID
  } alu_op_e;

  typedef enum logic [1:0] {
    BR_NONE, BR_EQ, BR_NE, BR_JAL
  } branch_e;

  typedef enum logic [2:0] {
    S_IDLE, S_FETCH, S_DECODE, S_EXECUTE, S_WRITEBACK, S_HALT
  } core_state_e;

  typedef enum logic [1:0] {
    HALT_NONE, HALT_ECALL, HALT_ILLEGAL, HALT_LIMIT
  } halt_cause_e;

endpackage

//--- design/rv_mini_top.sv
module rv_mini_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     prog_valid,
  output logic                     prog_ready,
  input  rv_mini_pkg::imem_addr_t  prog_addr,
  input  rv_mini_pkg::instr_t      prog_data,
  input  logic                     start,
  input  rv_mini_pkg::word_t       step_limit,
  output logic                     busy,
  output logic                     halted,
  output rv_mini_pkg::halt_cause_e halt_cause,
  output rv_mini_pkg::word_t       retired,
  input  rv_mini_pkg::reg_addr_t   dbg_addr,
  output rv_mini_pkg::word_t       dbg_data
);

  import rv_mini_pkg::*;

  logic      prog_we;
  logic      pc_reset;
  logic      fetch_en;
  logic      decode_en;
  logic      execute_en;
  logic      writeback_en;
  logic      illegal;
  logic      is_ecall;
  logic      limit_hit;
  word_t     fetch_pc;
  instr_t    instr;
  word_t     de_pc;
  word_t     rs1_data;
  word_t     rs2_data;
  reg_addr_t rd;
  word_t     immediate;
  alu_op_e   alu_op;
  branch_e   branch;
  logic      mem_read;
  logic      mem_write;
  logic      reg_write;
  logic      use_imm;
  logic      use_pc;
  logic      wb_en;
  reg_addr_t wb_rd;
  word_t     wb_data;
  word_t     next_pc;

  rv_sequencer u_sequencer (
    .clk(clk), .rst_n(rst_n), .start(start), .prog_valid(prog_valid),
    .illegal(illegal), .is_ecall(is_ecall), .limit_hit(limit_hit),
    .prog_ready(prog_ready), .prog_we(prog_we), .pc_reset(pc_reset),
    .fetch_en(fetch_en), .decode_en(decode_en), .execute_en(execute_en),
    .writeback_en(writeback_en), .busy(busy), .halted(halted), .halt_cause(halt_cause)
  );

  rv_retire_counter u_retire_counter (
    .clk(clk), .rst_n(rst_n), .start(start), .retire(writeback_en),
    .step_limit(step_limit), .retired(retired), .limit_hit(limit_hit)
  );

  rv_fetch u_fetch (
    .clk(clk), .rst_n(rst_n), .prog_we(prog_we), .prog_addr(prog_addr),
    .prog_data(prog_data), .pc_reset(pc_reset), .fetch_en(fetch_en),
    .writeback_en(writeback_en), .next_pc(next_pc), .pc(fetch_pc), .instr(instr)
  );

  rv_decode u_decode (
    .clk(clk), .rst_n(rst_n), .decode_en(decode_en), .instr(instr), .pc_in(fetch_pc),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .dbg_addr(dbg_addr),
    .pc(de_pc), .rs1_data(rs1_data), .rs2_data(rs2_data), .rd(rd),
    .immediate(immediate), .alu_op(alu_op), .branch(branch), .mem_read(mem_read),
    .mem_write(mem_write), .reg_write(reg_write), .use_imm(use_imm), .use_pc(use_pc),
    .illegal(illegal), .is_ecall(is_ecall), .dbg_data(dbg_data)
  );

  rv_execute u_execute (
    .clk(clk), .rst_n(rst_n), .execute_en(execute_en), .pc(de_pc),
    .rs1_data(rs1_data), .rs2_data(rs2_data), .rd(rd), .immediate(immediate),
    .alu_op(alu_op), .branch(branch), .mem_read(mem_read), .mem_write(mem_write),
    .reg_write(reg_write), .use_imm(use_imm), .use_pc(use_pc),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data), .next_pc(next_pc)
  );

endmodule

//--- design/rv_reg_file.sv
module rv_reg_file (
  input  logic                   clk,
  input  rv_mini_pkg::reg_addr_t a1,
  input  rv_mini_pkg::reg_addr_t a2,
  input  rv_mini_pkg::reg_addr_t a3,
  input  rv_mini_pkg::word_t     wd,
  input  logic                   we,
  input  rv_mini_pkg::reg_addr_t dbg_addr,
  output rv_mini_pkg::word_t     d1,
  output rv_mini_pkg::word_t     d2,
  output rv_mini_pkg::word_t     dbg_d
);

  import rv_mini_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (we) regs[a3] <= wd;
    regs[0] <= '0;  // Overrides any write to x0
  end

  assign d1    = regs[a1];
  assign d2    = regs[a2];
  assign dbg_d = regs[dbg_addr];

  a_x0_zero: assert property (@(posedge clk) (a1 == '0) |-> (d1 == '0));

endmodule

//--- design/rv_retire_counter.sv
module rv_retire_counter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  logic               retire,
  input  rv_mini_pkg::word_t step_limit,
  output rv_mini_pkg::word_t retired,
  output logic               limit_hit
);

  import rv_mini_pkg::*;

  word_t limit;
  word_t retired_inc;

  assign retired_inc = retired + 32'd1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      retired <= '0;
      limit   <= '0;
    end else if (start) begin
      retired <= '0;
      limit   <= step_limit;  // Held for the whole run
    end else if (retire) begin
      retired <= retired_inc;
    end
  end

  // Zero limit means run until ECALL or illegal
  assign limit_hit = (limit != '0) && (retired_inc == limit);

endmodule

//--- design/rv_sequencer.sv
module rv_sequencer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  logic                     prog_valid,
  input  logic                     illegal,
  input  logic                     is_ecall,
  input  logic                     limit_hit,
  output logic                     prog_ready,
  output logic                     prog_we,
  output logic                     pc_reset,
  output logic                     fetch_en,
  output logic                     decode_en,
  output logic                     execute_en,
  output logic                     writeback_en,
  output logic                     busy,
  output logic                     halted,
  output rv_mini_pkg::halt_cause_e halt_cause
);

  import rv_mini_pkg::*;

  core_state_e state;
  core_state_e state_nxt;
  halt_cause_e cause_nxt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      halt_cause <= HALT_NONE;
    end else begin
      state      <= state_nxt;
      halt_cause <= cause_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    cause_nxt = halt_cause;
    case (state)
      S_IDLE, S_HALT: begin
        if (start) begin
          state_nxt = S_FETCH;
          cause_nxt = HALT_NONE;  // Fresh run
        end
      end
      S_FETCH:     state_nxt = S_DECODE;
      S_DECODE: begin
        state_nxt = illegal ? S_HALT : S_EXECUTE;
        if (illegal) cause_nxt = HALT_ILLEGAL;
      end
      S_EXECUTE:   state_nxt = S_WRITEBACK;
      S_WRITEBACK: begin
        if (is_ecall) begin
          state_nxt = S_HALT;
          cause_nxt = HALT_ECALL;
        end else if (limit_hit) begin
          state_nxt = S_HALT;
          cause_nxt = HALT_LIMIT;
        end else begin
          state_nxt = S_FETCH;
        end
      end
      default:     state_nxt = S_IDLE;
    endcase
  end

  assign prog_ready   = (state == S_IDLE) || (state == S_HALT);
  assign prog_we      = prog_valid && prog_ready;
  assign pc_reset     = start && prog_ready;
  assign fetch_en     = (state == S_FETCH);
  assign decode_en    = (state == S_DECODE);
  assign execute_en   = (state == S_EXECUTE);
  assign writeback_en = (state == S_WRITEBACK);
  assign halted       = (state == S_HALT);
  assign busy         = !prog_ready;

  a_one_step: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> $onehot({fetch_en, decode_en, execute_en, writeback_en}));
  // Program memory must not change under a running program
  a_load_idle: assert property (@(posedge clk) disable iff (!rst_n)
    prog_we |-> !(fetch_en || decode_en || execute_en || writeback_en));

endmodule

//--- rv_mini.f
+incdir+design
design/rv_mini_pkg.sv
design/rv_fetch.sv
design/rv_reg_file.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_sequencer.sv
design/rv_retire_counter.sv
design/rv_mini_top.sv
verification/rv_mini_tb.sv

//--- verification/rv_mini_tb.sv
module rv_mini_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import rv_mini_pkg::*;

  localparam int CLK_HALF     = 20;
  localparam int RESET_CYCLES = 16;
  // Executed instructions per test: 8, 10, 21, 7, 3 (with the illegal word), 5 + 3
  localparam int EXEC_CYCLES    = 4 * (8 + 10 + 21 + 7 + 3 + 8);
  // Loaded words, two cycles each at most
  localparam int LOAD_CYCLES    = 2 * (8 + 10 + 11 + 1 + 5 + 5 + 3);
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + EXEC_CYCLES + LOAD_CYCLES + 200;

  logic        clk;
  logic        rst_n;
  logic        prog_valid;
  logic        prog_ready;
  imem_addr_t  prog_addr;
  instr_t      prog_data;
  logic        start;
  word_t       step_limit;
  logic        busy;
  logic        halted;
  halt_cause_e halt_cause;
  word_t       retired;
  reg_addr_t   dbg_addr;
  word_t       dbg_data;

  instr_t prog[$];  // Program image, word 0 first
  word_t  lfsr_state = 32'hb630_bb3f;
  int     cycle_count = 0;
  int     checks = 0;
  int     errors = 0;

  rv_mini_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_valid(prog_valid),
    .prog_ready(prog_ready),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .start     (start),
    .step_limit(step_limit),
    .busy      (busy),
    .halted    (halted),
    .halt_cause(halt_cause),
    .retired   (retired),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) cycle_count <= cycle_count + 1;

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles, the core did not halt in time", cycle_count);
    $display("*** TEST FAILED ***");
    $finish;
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic word_t lfsr_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  function automatic word_t sext12(input word_t v);
    return {{20{v[11]}}, v[11:0]};
  endfunction

  function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rd,
                                   input reg_addr_t rs1, input reg_addr_t rs2);
    return {f7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic instr_t enc_addi(input reg_addr_t rd, input reg_addr_t rs1,
                                      input word_t imm);
    return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic instr_t enc_lw(input reg_addr_t rd, input reg_addr_t rs1, input word_t imm);
    return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic instr_t enc_sw(input reg_addr_t rs2, input reg_addr_t rs1, input word_t imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic instr_t enc_branch(input logic [2:0] f3, input reg_addr_t rs1,
                                        input reg_addr_t rs2, input word_t imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic instr_t enc_jal(input reg_addr_t rd, input word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic instr_t enc_lui(input reg_addr_t rd, input word_t imm);
    return {imm[31:12], rd, 7'b0110111};
  endfunction

  function automatic instr_t enc_ecall();
    return {25'b0, 7'b1110011};
  endfunction

  // LUI + ADDI pair, upper part rounded for the sign of the low 12 bits
  task automatic emit_const(input reg_addr_t rd, input word_t v);
    logic [19:0] upper;
    upper = v[31:12] + {19'b0, v[11]};
    prog.push_back(enc_lui(rd, {upper, 12'h000}));
    prog.push_back(enc_addi(rd, rd, {20'b0, v[11:0]}));
  endtask

  task automatic check_eq(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic load_program();
    int idx;
    idx = 0;
    while (idx < prog.size()) begin
      @(posedge clk);
      prog_valid <= 1'b1;
      prog_addr  <= imem_addr_t'(idx);
      prog_data  <= prog[idx];
      @(negedge clk);
      if (prog_ready) idx++;  // Taken on the coming edge
    end
    @(posedge clk);
    prog_valid <= 1'b0;
  endtask

  // Optionally keeps a load request pending for the first cycles of the run
  task automatic run_program(input word_t limit, input logic poke, output int cycles);
    @(posedge clk);
    start      <= 1'b1;
    step_limit <= limit;
    @(posedge clk);
    start <= 1'b0;
    if (poke) begin
      prog_valid <= 1'b1;
      prog_addr  <= imem_addr_t'(1);  // Not yet fetched when the poke starts
      prog_data  <= enc_ecall();
    end
    cycles = 0;
    @(negedge clk);
    while (!halted) begin
      checks++;
      if (prog_ready || !busy) begin
        errors++;
        $display("Load port was ready or core not busy while the program ran");
      end
      cycles++;
      @(posedge clk);
      if (cycles == 8) prog_valid <= 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic check_reg(input reg_addr_t r, input word_t exp);
    @(posedge clk);
    dbg_addr <= r;
    @(negedge clk);
    check_eq($sformatf("dbg_data[x%0d]", r), dbg_data, exp);
  endtask

  task automatic check_halt(input halt_cause_e cause, input word_t count,
                            input int exp_cycles, input int cycles);
    check_eq("halt_cause", word_t'(halt_cause), word_t'(cause));
    check_eq("retired", retired, count);
    check_eq("busy", word_t'(busy), 32'd0);
    checks++;
    if (cycles != exp_cycles) begin
      errors++;
      $display("Core halted %0d cycles after start instead of %0d", cycles, exp_cycles);
    end
  endtask

  task automatic test_arith();
    word_t a;
    word_t b;
    int    cycles;
    a = lfsr_bits(32);
    b = lfsr_bits(32);
    prog.delete();
    emit_const(5'd1, a);
    emit_const(5'd2, b);
    prog.push_back(enc_r(7'b0000000, 5'd3, 5'd1, 5'd2));  // ADD
    prog.push_back(enc_r(7'b0100000, 5'd4, 5'd1, 5'd2));  // SUB
    prog.push_back(enc_r(7'b0100000, 5'd5, 5'd2, 5'd1));
    prog.push_back(enc_ecall());
    load_program();
    run_program(32'd0, 1'b0, cycles);
    check_halt(HALT_ECALL, 32'd8, 32, cycles);
    check_reg(5'd1, a);
    check_reg(5'd2, b);
    check_reg(5'd3, a + b);
    check_reg(5'd4, a - b);
    check_reg(5'd5, b - a);
  endtask

  task automatic test_memory();
    word_t v1;
    word_t v2;
    int    cycles;
    v1 = lfsr_bits(32);
    v2 = lfsr_bits(32);
    prog.delete();
    emit_const(5'd1, v1);
    emit_const(5'd2, v2);
    prog.push_back(enc_addi(5'd3, 5'd0, 32'd64));  // Base address
    prog.push_back(enc_sw(5'd1, 5'd3, 32'd0));
    prog.push_back(enc_sw(5'd2, 5'd3, -32'sd4));  // Negative offset
    prog.push_back(enc_lw(5'd4, 5'd3, -32'sd4));
    prog.push_back(enc_lw(5'd5, 5'd3, 32'd0));
    prog.push_back(enc_ecall());
    load_program();
    run_program(32'd0, 1'b0, cycles);
    check_halt(HALT_ECALL, 32'd10, 40, cycles);
    check_reg(5'd4, v2);
    check_reg(5'd5, v1);
  endtask

  task automatic test_control();
    int loops;
    int executed;
    int cycles;
    loops    = 5;
    executed = 2 + 3 * loops + 4;  // Setup, loop body, then x6 set, BEQ, JAL, ECALL
    prog.delete();
    prog.push_back(enc_addi(5'd1, 5'd0, loops));           // 0
    prog.push_back(enc_addi(5'd2, 5'd0, 32'd0));           // 4
    prog.push_back(enc_addi(5'd2, 5'd2, 32'd1));           // 8 loop top
    prog.push_back(enc_addi(5'd1, 5'd1, -32'sd1));         // 12
    prog.push_back(enc_branch(3'b001, 5'd1, 5'd0, -32'sd8));  // 16 BNE
    prog.push_back(enc_addi(5'd6, 5'd0, 32'd77));          // 20
    prog.push_back(enc_branch(3'b000, 5'd0, 5'd0, 32'd8));   // 24 BEQ taken
    prog.push_back(enc_addi(5'd6, 5'd0, 32'd99));          // 28 skipped
    prog.push_back(enc_jal(5'd7, 32'd8));                  // 32
    prog.push_back(enc_addi(5'd6, 5'd0, 32'd55));          // 36 skipped
    prog.push_back(enc_ecall());                           // 40
    load_program();
    run_program(32'd0, 1'b0, cycles);
    check_halt(HALT_ECALL, executed, 4 * executed, cycles);
    check_reg(5'd1, 32'd0);
    check_reg(5'd2, loops);
    check_reg(5'd6, 32'd77);
    check_reg(5'd7, 32'd36);  // JAL at 32
  endtask

  task automatic test_step_limit();
    int cycles;
    prog.delete();
    prog.push_back(enc_jal(5'd0, 32'd0));  // Jump to self
    load_program();
    run_program(32'd7, 1'b0, cycles);
    check_halt(HALT_LIMIT, 32'd7, 28, cycles);
  endtask

  task automatic test_illegal();
    word_t keep;
    word_t junk;
    int    cycles;
    keep = lfsr_bits(11);
    junk = lfsr_bits(12);
    prog.delete();
    prog.push_back(enc_addi(5'd12, 5'd0, keep));
    prog.push_back(enc_addi(5'd0, 5'd0, junk));
    prog.push_back({12'h005, 5'd0, 3'b000, 5'd12, 7'b0001011});  // Undefined opcode
    prog.push_back(enc_addi(5'd12, 5'd0, 32'd1));
    prog.push_back(enc_ecall());
    load_program();
    run_program(32'd0, 1'b0, cycles);
    check_halt(HALT_ILLEGAL, 32'd2, 4 * 2 + 2, cycles);  // Halts out of decode
    check_reg(5'd0, 32'd0);
    check_reg(5'd12, keep);
  endtask

  task automatic test_load_port();
    word_t a;
    word_t b;
    int    cycles;
    a = lfsr_bits(12);
    b = lfsr_bits(12);
    prog.delete();
    prog.push_back(enc_addi(5'd13, 5'd0, a));
    prog.push_back(enc_addi(5'd13, 5'd13, a));
    prog.push_back(enc_addi(5'd13, 5'd13, a));
    prog.push_back(enc_addi(5'd13, 5'd13, a));
    prog.push_back(enc_ecall());
    load_program();
    run_program(32'd0, 1'b1, cycles);  // Pending load must not land
    check_halt(HALT_ECALL, 32'd5, 20, cycles);
    check_reg(5'd13, 4 * sext12(a));
    // Reload straight from the halt state
    prog.delete();
    prog.push_back(enc_addi(5'd14, 5'd0, b));
    prog.push_back(enc_r(7'b0100000, 5'd15, 5'd14, 5'd13));
    prog.push_back(enc_ecall());
    load_program();
    run_program(32'd0, 1'b0, cycles);
    check_halt(HALT_ECALL, 32'd3, 12, cycles);
    check_reg(5'd15, sext12(b) - 4 * sext12(a));
  endtask

  initial begin
    rst_n      = 1'b0;
    prog_valid = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    start      = 1'b0;
    step_limit = '0;
    dbg_addr   = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_eq("prog_ready", word_t'(prog_ready), 32'd1);
    check_eq("busy", word_t'(busy), 32'd0);
    check_eq("halted", word_t'(halted), 32'd0);
    check_eq("halt_cause", word_t'(halt_cause), word_t'(HALT_NONE));

    test_arith();
    test_memory();
    test_control();
    test_step_limit();
    test_illegal();
    test_load_port();

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
